//--- soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // bus widths, word addressed
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // 8 MB region select bits of the word address
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 21;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // address map
    localparam logic [REGION_W-1:0] MEM_REGION = 9'h000;
    localparam logic [REGION_W-1:0] SYS_REGION = 9'h001;
    localparam logic [ADDR_W-1:0]   SSEG_ADDR  = 30'h0040_0000;

    // on-chip ram depth, aliases across its region
    localparam int RAM_AW = 10;

    // system control register block
    localparam logic [DATA_W-1:0] SYS_ID_VALUE    = 32'h2019_1028;
    localparam logic [3:0]        SYS_OFF_ID      = 4'h0;
    localparam logic [3:0]        SYS_OFF_SCRATCH = 4'h1;
    localparam logic [3:0]        SYS_OFF_ERRADDR = 4'h2;
    localparam logic [3:0]        SYS_OFF_POWER   = 4'h3;
    localparam logic [3:0]        SYS_OFF_IRQ     = 4'h4;

    // display digit count, one nibble each
    localparam int SSEG_DIGITS = 8;

    // hex font, active low, bit 0 is segment a
    function automatic logic [6:0] sseg_font(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        // table is active high, pins are not
        return ~seg;
    endfunction

endpackage

`default_nettype wire

//--- wb_pri_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_pri_arbiter import soc_bus_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    // port a, high priority
    input  logic              i_a_cyc,
    input  logic              i_a_stb,
    input  logic              i_a_we,
    input  logic [ADDR_W-1:0] i_a_addr,
    input  logic [DATA_W-1:0] i_a_data,
    input  logic [SEL_W-1:0]  i_a_sel,
    output logic              o_a_ack,
    output logic              o_a_stall,
    output logic              o_a_err,
    // port b, debug side
    input  logic              i_b_cyc,
    input  logic              i_b_stb,
    input  logic              i_b_we,
    input  logic [ADDR_W-1:0] i_b_addr,
    input  logic [DATA_W-1:0] i_b_data,
    input  logic [SEL_W-1:0]  i_b_sel,
    output logic              o_b_ack,
    output logic              o_b_stall,
    output logic              o_b_err,
    // merged slave side
    output logic              o_cyc,
    output logic              o_stb,
    output logic              o_we,
    output logic [ADDR_W-1:0] o_addr,
    output logic [DATA_W-1:0] o_data,
    output logic [SEL_W-1:0]  o_sel,
    input  logic              i_ack,
    input  logic              i_stall,
    input  logic              i_err
);

    // registered owner, one hot or idle
    logic r_own_a;
    logic r_own_b;
    // effective grant this cycle
    logic grant_a;
    logic grant_b;

    // idle bus goes straight to a requester, a first
    assign grant_a = r_own_a || (!r_own_b && i_a_cyc);
    assign grant_b = r_own_b || (!r_own_a && !i_a_cyc && i_b_cyc);

    // owner keeps the bus until its cyc drops
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_own_a <= 1'b0;
            r_own_b <= 1'b0;
        end else begin
            r_own_a <= grant_a && i_a_cyc;
            r_own_b <= grant_b && i_b_cyc;
        end
    end

    // cyc and stb only from the granted port
    assign o_cyc = (grant_a && i_a_cyc) || (grant_b && i_b_cyc);
    assign o_stb = (grant_a && i_a_stb) || (grant_b && i_b_stb);

    // payload mux, a by default
    assign o_we   = grant_b ? i_b_we   : i_a_we;
    assign o_addr = grant_b ? i_b_addr : i_a_addr;
    assign o_data = grant_b ? i_b_data : i_a_data;
    assign o_sel  = grant_b ? i_b_sel  : i_a_sel;

    // responses back to the owner only
    assign o_a_ack = grant_a && i_ack;
    assign o_a_err = grant_a && i_err;
    assign o_b_ack = grant_b && i_ack;
    assign o_b_err = grant_b && i_err;

    // loser is held off
    assign o_a_stall = grant_a ? i_stall : 1'b1;
    assign o_b_stall = grant_b ? i_stall : 1'b1;

    a_one_owner : assert property (@(posedge i_clk) disable iff (i_rst)
        !(grant_a && grant_b));

    // acks come two cycles late, master must still be in its cycle
    a_ack_in_cyc : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_a_ack |-> i_a_cyc) and (o_b_ack |-> i_b_cyc));

endmodule

`default_nettype wire

//--- bus_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module bus_decoder import soc_bus_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_stb,
    input  logic [ADDR_W-1:0] i_addr,
    // per slave strobes
    output logic              o_mem_stb,
    output logic              o_sys_stb,
    output logic              o_sseg_stb,
    // slave returns
    input  logic              i_mem_ack,
    input  logic [DATA_W-1:0] i_mem_data,
    input  logic              i_sys_ack,
    input  logic [DATA_W-1:0] i_sys_data,
    input  logic              i_sseg_ack,
    input  logic [DATA_W-1:0] i_sseg_data,
    // back toward the arbiter
    output logic              o_ack,
    output logic              o_err,
    output logic [DATA_W-1:0] o_data,
    // same cycle error pulse for the error address register
    output logic              o_bus_err
);

    logic [REGION_W-1:0] region;
    logic                mem_sel;
    logic                sys_sel;
    logic                sseg_sel;
    logic                none_sel;

    assign region = i_addr[REGION_MSB:REGION_LSB];

    // region decode, display is a single word
    assign mem_sel  = (region == MEM_REGION);
    assign sys_sel  = (region == SYS_REGION);
    assign sseg_sel = (i_addr == SSEG_ADDR);
    assign none_sel = !mem_sel && !sys_sel && !sseg_sel;

    assign o_mem_stb  = i_stb && mem_sel;
    assign o_sys_stb  = i_stb && sys_sel;
    assign o_sseg_stb = i_stb && sseg_sel;

    // unmapped strobe, nobody will ack it
    assign o_bus_err = i_stb && none_sel;

    // err one cycle after the strobe, ack one after the slave
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ack <= 1'b0;
            o_err <= 1'b0;
        end else begin
            o_ack <= i_mem_ack || i_sys_ack || i_sseg_ack;
            o_err <= o_bus_err;
        end
    end

    // return data, sys wins over mem over sseg
    always_ff @(posedge i_clk) begin
        if (i_sys_ack) begin
            o_data <= i_sys_data;
        end else if (i_mem_ack) begin
            o_data <= i_mem_data;
        end else if (i_sseg_ack) begin
            o_data <= i_sseg_data;
        end else begin
            o_data <= '0;
        end
    end

    // slave ack and decode error come from disjoint strobes
    a_ack_err_excl : assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_ack && o_err));

endmodule

`default_nettype wire

//--- sys_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_regs import soc_bus_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_stb,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_bus_err,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_data,
    output logic              o_irq
);

    logic [DATA_W-1:0] r_scratch;
    logic [ADDR_W-1:0] r_err_addr;
    logic [DATA_W-1:0] r_power;
    logic [3:0]        offset;

    // register select from the low word bits
    assign offset = i_addr[3:0];

    // writes, scratch and irq bit only
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_irq <= 1'b0;
        end else if (i_stb && i_we && (offset == SYS_OFF_IRQ)) begin
            o_irq <= i_data[0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we && (offset == SYS_OFF_SCRATCH)) begin
            r_scratch <= i_data;
        end
    end

    // erroring address is still on the bus during the pulse
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_err_addr <= '0;
        end else if (i_bus_err) begin
            r_err_addr <= i_addr;
        end
    end

    // cycles since reset
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_power <= '0;
        end else if (!r_power[DATA_W-1]) begin
            r_power <= r_power + 1'b1;
        end else begin
            // top bit sticks, the rest wraps
            r_power[DATA_W-2:0] <= r_power[DATA_W-2:0] + 1'b1;
        end
    end

    // single cycle ack
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // read mux, unused offsets give zero
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (offset)
                SYS_OFF_ID:      o_data <= SYS_ID_VALUE;
                SYS_OFF_SCRATCH: o_data <= r_scratch;
                // reported as a byte address
                SYS_OFF_ERRADDR: o_data <= {r_err_addr, 2'b00};
                SYS_OFF_POWER:   o_data <= r_power;
                SYS_OFF_IRQ:     o_data <= {{(DATA_W-1){1'b0}}, o_irq};
                default:         o_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- wb_ram.sv
`timescale 1ns/100ps
`default_nettype none

module wb_ram import soc_bus_pkg::*; (
    input  logic              i_clk,
    input  logic              i_stb,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic [SEL_W-1:0]  i_sel,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_data
);

    logic [DATA_W-1:0] mem [2**RAM_AW];
    logic [RAM_AW-1:0] idx;

    // only the low bits, upper region bits alias
    assign idx = i_addr[RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int lane = 0; lane < SEL_W; lane++) begin
                if (i_sel[lane]) begin
                    mem[idx][8*lane +: 8] <= i_data[8*lane +: 8];
                end
            end
        end
    end

    // read returns the old word on a write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= mem[idx];
        end
    end

    // reads and writes ack alike, next cycle
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule

`default_nettype wire

//--- sseg_display.sv
`timescale 1ns/100ps
`default_nettype none

module sseg_display import soc_bus_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_stb,
    input  logic                     i_we,
    input  logic [DATA_W-1:0]        i_data,
    output logic                     o_ack,
    output logic [DATA_W-1:0]        o_data,
    output logic [7*SSEG_DIGITS-1:0] o_sseg
);

    // value shown, one nibble per digit
    logic [DATA_W-1:0] r_value;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_value <= '0;
        end else if (i_stb && i_we) begin
            r_value <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // readback is the register itself
    assign o_data = r_value;

    // digit 0 in the low bits
    for (genvar d = 0; d < SSEG_DIGITS; d++) begin : g_digit
        assign o_sseg[7*d +: 7] = sseg_font(r_value[4*d +: 4]);
    end

endmodule

`default_nettype wire

//--- soc_bus_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst,
    // master a, core side
    input  logic                     i_a_cyc,
    input  logic                     i_a_stb,
    input  logic                     i_a_we,
    input  logic [ADDR_W-1:0]        i_a_addr,
    input  logic [DATA_W-1:0]        i_a_data,
    input  logic [SEL_W-1:0]         i_a_sel,
    output logic                     o_a_ack,
    output logic                     o_a_stall,
    output logic                     o_a_err,
    // master b, debug side
    input  logic                     i_b_cyc,
    input  logic                     i_b_stb,
    input  logic                     i_b_we,
    input  logic [ADDR_W-1:0]        i_b_addr,
    input  logic [DATA_W-1:0]        i_b_data,
    input  logic [SEL_W-1:0]         i_b_sel,
    output logic                     o_b_ack,
    output logic                     o_b_stall,
    output logic                     o_b_err,
    // shared read data for both masters
    output logic [DATA_W-1:0]        o_data,
    output logic                     o_irq,
    output logic [7*SSEG_DIGITS-1:0] o_sseg
);

    // merged bus
    logic              bus_stb;
    logic              bus_we;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_data;
    logic [SEL_W-1:0]  bus_sel;
    logic              bus_ack;
    logic              bus_err;

    // decoder to slaves
    logic              mem_stb;
    logic              sys_stb;
    logic              sseg_stb;
    logic              mem_ack;
    logic              sys_ack;
    logic              sseg_ack;
    logic [DATA_W-1:0] mem_data;
    logic [DATA_W-1:0] sys_data;
    logic [DATA_W-1:0] sseg_data;
    logic              err_pulse;

    wb_pri_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_addr  (i_a_addr),
        .i_a_data  (i_a_data),
        .i_a_sel   (i_a_sel),
        .o_a_ack   (o_a_ack),
        .o_a_stall (o_a_stall),
        .o_a_err   (o_a_err),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_addr  (i_b_addr),
        .i_b_data  (i_b_data),
        .i_b_sel   (i_b_sel),
        .o_b_ack   (o_b_ack),
        .o_b_stall (o_b_stall),
        .o_b_err   (o_b_err),
        // none of these slaves looks at cyc
        .o_cyc     (),
        .o_stb     (bus_stb),
        .o_we      (bus_we),
        .o_addr    (bus_addr),
        .o_data    (bus_data),
        .o_sel     (bus_sel),
        .i_ack     (bus_ack),
        // slaves never stall
        .i_stall   (1'b0),
        .i_err     (bus_err)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_stb       (bus_stb),
        .i_addr      (bus_addr),
        .o_mem_stb   (mem_stb),
        .o_sys_stb   (sys_stb),
        .o_sseg_stb  (sseg_stb),
        .i_mem_ack   (mem_ack),
        .i_mem_data  (mem_data),
        .i_sys_ack   (sys_ack),
        .i_sys_data  (sys_data),
        .i_sseg_ack  (sseg_ack),
        .i_sseg_data (sseg_data),
        .o_ack       (bus_ack),
        .o_err       (bus_err),
        .o_data      (o_data),
        .o_bus_err   (err_pulse)
    );

    sys_ctrl_regs u_sys (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_stb     (sys_stb),
        .i_we      (bus_we),
        .i_addr    (bus_addr),
        .i_data    (bus_data),
        .i_bus_err (err_pulse),
        .o_ack     (sys_ack),
        .o_data    (sys_data),
        .o_irq     (o_irq)
    );

    wb_ram u_ram (
        .i_clk  (i_clk),
        .i_stb  (mem_stb),
        .i_we   (bus_we),
        .i_addr (bus_addr),
        .i_data (bus_data),
        .i_sel  (bus_sel),
        .o_ack  (mem_ack),
        .o_data (mem_data)
    );

    sseg_display u_sseg (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_stb  (sseg_stb),
        .i_we   (bus_we),
        .i_data (bus_data),
        .o_ack  (sseg_ack),
        .o_data (sseg_data),
        .o_sseg (o_sseg)
    );

endmodule

`default_nettype wire

//--- soc_bus_tb.sv
`timescale 1ns/100ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int MAX_VEC    = 64;
    localparam int RESP_LIMIT = 16;
    // sys block registers by full word address
    localparam logic [ADDR_W-1:0] POWER_ADDR = {SYS_REGION, 17'h0, SYS_OFF_POWER};
    localparam logic [ADDR_W-1:0] IRQ_ADDR   = {SYS_REGION, 17'h0, SYS_OFF_IRQ};
    // ram words used by the contention and pipelining tests
    localparam logic [ADDR_W-1:0] ARB_ADDR_A = 30'h0000_0020;
    localparam logic [ADDR_W-1:0] ARB_ADDR_B = 30'h0000_0021;
    localparam logic [ADDR_W-1:0] PIPE_ADDR0 = 30'h0000_0010;
    localparam logic [ADDR_W-1:0] PIPE_ADDR1 = 30'h0000_0011;

    logic                     clk;
    logic                     rst;
    logic                     a_cyc;
    logic                     a_stb;
    logic                     a_we;
    logic [ADDR_W-1:0]        a_addr;
    logic [DATA_W-1:0]        a_wdat;
    logic [SEL_W-1:0]         a_sel;
    logic                     a_ack;
    logic                     a_stall;
    logic                     a_err;
    logic                     b_cyc;
    logic                     b_stb;
    logic                     b_we;
    logic [ADDR_W-1:0]        b_addr;
    logic [DATA_W-1:0]        b_wdat;
    logic [SEL_W-1:0]         b_sel;
    logic                     b_ack;
    logic                     b_stall;
    logic                     b_err;
    logic [DATA_W-1:0]        rdata;
    logic                     irq;
    logic [7*SSEG_DIGITS-1:0] sseg;

    // seven words per vector line
    logic [31:0]       vec_mem [7*MAX_VEC];
    // expected ram contents indexed like the ram
    logic [DATA_W-1:0] ram_model [int];
    logic [15:0]       lfsr;
    logic [DATA_W-1:0] last_power;
    int                n_vec;
    int                checks = 0;
    int                errors = 0;
    int                cycles = 0;
    int                cycle_limit = 1000;
    int                acks_a = 0;
    int                acks_b = 0;
    int                exp_acks_a = 0;
    int                exp_acks_b = 0;

    soc_bus_top uut (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_a_cyc   (a_cyc),
        .i_a_stb   (a_stb),
        .i_a_we    (a_we),
        .i_a_addr  (a_addr),
        .i_a_data  (a_wdat),
        .i_a_sel   (a_sel),
        .o_a_ack   (a_ack),
        .o_a_stall (a_stall),
        .o_a_err   (a_err),
        .i_b_cyc   (b_cyc),
        .i_b_stb   (b_stb),
        .i_b_we    (b_we),
        .i_b_addr  (b_addr),
        .i_b_data  (b_wdat),
        .i_b_sel   (b_sel),
        .o_b_ack   (b_ack),
        .o_b_stall (b_stall),
        .o_b_err   (b_err),
        .o_data    (rdata),
        .o_irq     (irq),
        .o_sseg    (sseg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit is set once the vectors are loaded
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run still busy after %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // acks seen per port sampled mid cycle
    always @(negedge clk) begin
        if (a_ack) begin
            acks_a++;
        end
        if (b_ack) begin
            acks_b++;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // port 0 is master a and port 1 is master b
    task automatic drive_port(input int port, input logic c, input logic s, input logic w,
                              input logic [ADDR_W-1:0] ad, input logic [DATA_W-1:0] d,
                              input logic [SEL_W-1:0] sl);
        if (port == 0) begin
            a_cyc  = c;
            a_stb  = s;
            a_we   = w;
            a_addr = ad;
            a_wdat = d;
            a_sel  = sl;
        end else begin
            b_cyc  = c;
            b_stb  = s;
            b_we   = w;
            b_addr = ad;
            b_wdat = d;
            b_sel  = sl;
        end
    endtask

    function automatic logic port_stall(input int port);
        return (port == 0) ? a_stall : b_stall;
    endfunction

    function automatic logic port_ack(input int port);
        return (port == 0) ? a_ack : b_ack;
    endfunction

    function automatic logic port_err(input int port);
        return (port == 0) ? a_err : b_err;
    endfunction

    task automatic count_ack(input int port);
        if (port == 0) begin
            exp_acks_a++;
        end else begin
            exp_acks_b++;
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per data bit
    task automatic rand_word(output logic [DATA_W-1:0] w);
        for (int k = 0; k < DATA_W; k++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic model_write(input logic [ADDR_W-1:0] ad, input logic [DATA_W-1:0] d,
                               input logic [SEL_W-1:0] sl);
        int                idx;
        logic [DATA_W-1:0] word;
        idx = ad[RAM_AW-1:0];
        word = ram_model.exists(idx) ? ram_model[idx] : 'x;
        // only enabled lanes change
        for (int lane = 0; lane < SEL_W; lane++) begin
            if (sl[lane]) begin
                word[8*lane +: 8] = d[8*lane +: 8];
            end
        end
        ram_model[idx] = word;
    endtask

    function automatic logic [7*SSEG_DIGITS-1:0] font_all(input logic [DATA_W-1:0] v);
        logic [7*SSEG_DIGITS-1:0] segs;
        for (int dg = 0; dg < SSEG_DIGITS; dg++) begin
            segs[7*dg +: 7] = sseg_font(v[4*dg +: 4]);
        end
        return segs;
    endfunction

    // one full bus cycle that returns at the negedge where cyc drops
    task automatic bus_txn(input int port, input logic w, input logic [ADDR_W-1:0] ad,
                           input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] sl,
                           output logic [DATA_W-1:0] rd, output logic got_ack,
                           output logic got_err, output int lat, output int stalls);
        @(negedge clk);
        drive_port(port, 1'b1, 1'b1, w, ad, d, sl);
        stalls = 0;
        // stall has settled a quarter period after the drive
        #(CLK_PERIOD / 4);
        while (port_stall(port) && stalls < RESP_LIMIT) begin
            stalls++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        if (port_stall(port)) begin
            errors++;
            $display("port %0d was never granted the bus at %0t ns", port, $time);
        end
        // accepted on this edge
        @(posedge clk);
        @(negedge clk);
        drive_port(port, 1'b1, 1'b0, w, ad, d, sl);
        lat = 1;
        while (!port_ack(port) && !port_err(port) && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        got_ack = port_ack(port);
        got_err = port_err(port);
        rd = rdata;
        if (!got_ack && !got_err) begin
            errors++;
            $display("no ack or err on port %0d for address %h", port, ad);
        end
        // cyc stays up through the edge that takes the response
        @(negedge clk);
        drive_port(port, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic run_vector(input int i);
        int                port;
        string             pn;
        logic              w;
        logic [ADDR_W-1:0] ad;
        logic [DATA_W-1:0] d;
        logic [SEL_W-1:0]  sl;
        logic [DATA_W-1:0] exp_d;
        logic              exp_err;
        logic [DATA_W-1:0] rd;
        logic              got_ack;
        logic              got_err;
        int                lat;
        int                stalls;
        port    = vec_mem[7*i];
        w       = vec_mem[7*i+1][0];
        ad      = vec_mem[7*i+2][ADDR_W-1:0];
        d       = vec_mem[7*i+3];
        sl      = vec_mem[7*i+4][SEL_W-1:0];
        exp_d   = vec_mem[7*i+5];
        exp_err = vec_mem[7*i+6][0];
        pn      = (port == 0) ? "a" : "b";
        bus_txn(port, w, ad, d, sl, rd, got_ack, got_err, lat, stalls);
        check($sformatf("o_%s_err", pn), got_err, exp_err);
        check($sformatf("o_%s_ack", pn), got_ack, !exp_err);
        // err one cycle after acceptance and ack two
        check($sformatf("o_%s response latency", pn), lat, exp_err ? 1 : 2);
        check($sformatf("o_%s_stall cycles", pn), stalls, 0);
        if (!exp_err && !w) begin
            if (ad == POWER_ADDR) begin
                check("power counter at least floor", rd >= exp_d, 1'b1);
                check("power counter rising", rd > last_power, 1'b1);
                last_power = rd;
            end else begin
                check("o_data", rd, exp_d);
            end
        end
        if (!exp_err && w) begin
            if (ad[REGION_MSB:REGION_LSB] == MEM_REGION) begin
                model_write(ad, d, sl);
            end
            if (ad == IRQ_ADDR) begin
                check("o_irq", irq, d[0]);
            end
            if (ad == SSEG_ADDR) begin
                check("o_sseg", sseg, font_all(d));
            end
        end
        if (!exp_err) begin
            count_ack(port);
        end
    endtask

    task automatic read_check(input int port, input logic [ADDR_W-1:0] ad,
                              input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] rd;
        logic              got_ack;
        logic              got_err;
        int                lat;
        int                stalls;
        bus_txn(port, 1'b0, ad, '0, 4'hf, rd, got_ack, got_err, lat, stalls);
        check("o_ack on readback", got_ack, 1'b1);
        check("o_data", rd, exp);
        count_ack(port);
    endtask

    // both masters raise cyc on the same edge
    task automatic arbitration_test();
        logic [DATA_W-1:0] da;
        logic [DATA_W-1:0] db;
        logic [DATA_W-1:0] rd_a;
        logic [DATA_W-1:0] rd_b;
        logic              ack_a;
        logic              ack_b;
        logic              err_a;
        logic              err_b;
        int                lat_a;
        int                lat_b;
        int                st_a;
        int                st_b;
        time               done_a;
        time               done_b;
        rand_word(da);
        rand_word(db);
        fork
            begin
                bus_txn(0, 1'b1, ARB_ADDR_A, da, 4'hf, rd_a, ack_a, err_a, lat_a, st_a);
                done_a = $time;
            end
            begin
                bus_txn(1, 1'b1, ARB_ADDR_B, db, 4'hf, rd_b, ack_b, err_b, lat_b, st_b);
                done_b = $time;
            end
        join
        check("o_a_ack", ack_a, 1'b1);
        check("o_b_ack", ack_b, 1'b1);
        check("o_a_err", err_a, 1'b0);
        check("o_b_err", err_b, 1'b0);
        check("o_a_stall cycles", st_a, 0);
        // b held off while a owns the bus
        check("o_b_stall seen", st_b > 0, 1'b1);
        check("port a done before port b", done_a < done_b, 1'b1);
        check("o_a response latency", lat_a, 2);
        check("o_b response latency", lat_b, 2);
        count_ack(0);
        count_ack(1);
        model_write(ARB_ADDR_A, da, 4'hf);
        model_write(ARB_ADDR_B, db, 4'hf);
        read_check(0, ARB_ADDR_A, da);
        read_check(1, ARB_ADDR_B, db);
    endtask

    // two reads back to back with answers in order
    task automatic pipeline_test();
        logic [DATA_W-1:0] exp0;
        logic [DATA_W-1:0] exp1;
        exp0 = ram_model[PIPE_ADDR0[RAM_AW-1:0]];
        exp1 = ram_model[PIPE_ADDR1[RAM_AW-1:0]];
        @(negedge clk);
        drive_port(0, 1'b1, 1'b1, 1'b0, PIPE_ADDR0, '0, 4'hf);
        #(CLK_PERIOD / 4);
        check("o_a_stall", a_stall, 1'b0);
        @(negedge clk);
        drive_port(0, 1'b1, 1'b1, 1'b0, PIPE_ADDR1, '0, 4'hf);
        #(CLK_PERIOD / 4);
        check("o_a_stall", a_stall, 1'b0);
        @(negedge clk);
        drive_port(0, 1'b1, 1'b0, 1'b0, PIPE_ADDR1, '0, 4'hf);
        check("o_a_ack first read", a_ack, 1'b1);
        check("o_data first read", rdata, exp0);
        @(negedge clk);
        check("o_a_ack second read", a_ack, 1'b1);
        check("o_data second read", rdata, exp1);
        @(negedge clk);
        drive_port(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        exp_acks_a += 2;
    endtask

    initial begin
        rst = 1'b1;
        drive_port(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        lfsr = 16'd8;
        last_power = '0;
        $readmemh("soc_bus_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && !$isunknown(vec_mem[7*n_vec])) begin
            n_vec++;
        end
        cycle_limit = 20 * n_vec + 200;
        if (n_vec == 0) begin
            errors++;
            $display("no vectors could be read from soc_bus_vectors.txt");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        arbitration_test();
        pipeline_test();
        repeat (2) @(negedge clk);
        // any stray ack on the wrong port shows up here
        check("o_a_ack count", acks_a, exp_acks_a);
        check("o_b_ack count", acks_b, exp_acks_b);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_bus_vectors.txt
// columns: master we word_addr wdata sel rdata err, all hex, one bus transfer per line
// rdata is checked on reads only, and for the power counter it is a lower bound
0 1 00000010 11223344 f 00000000 0
0 0 00000010 00000000 f 11223344 0
1 1 00000011 a5a5a5a5 f 00000000 0
0 1 00000011 000000cc 1 00000000 0
1 1 00000011 00ee0000 4 00000000 0
1 0 00000011 00000000 f a5eea5cc 0
0 1 00000012 00000000 f 00000000 0
1 1 00000012 deadbeef c 00000000 0
0 0 00000012 00000000 f dead0000 0
1 0 001ffc10 00000000 f 11223344 0
0 0 00200000 00000000 f 20191028 0
1 1 00200001 cafef00d f 00000000 0
0 0 00200001 00000000 f cafef00d 0
0 0 00200003 00000000 f 00000001 0
0 1 00200004 00000001 f 00000000 0
1 0 00200004 00000000 f 00000001 0
0 0 00200007 00000000 f 00000000 0
0 1 00600000 12345678 f 00000000 1
1 0 00200002 00000000 f 01800000 0
1 0 00400001 00000000 f 00000000 1
0 0 00200002 00000000 f 01000004 0
1 1 00400000 01234567 f 00000000 0
0 0 00400000 00000000 f 01234567 0
0 1 00400000 89abcdef f 00000000 0
1 0 00400000 00000000 f 89abcdef 0
1 1 00200004 fffffffe f 00000000 0
0 0 00200004 00000000 f 00000000 0
1 0 3fffffff 00000000 f 00000000 1
0 0 00200002 00000000 f fffffffc 0
1 0 00200003 00000000 f 00000001 0

//--- soc_bus.f
soc_bus_pkg.sv
wb_pri_arbiter.sv
bus_decoder.sv
sys_ctrl_regs.sv
wb_ram.sv
sseg_display.sv
soc_bus_top.sv
soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - soc_bus_pkg.sv
  - wb_pri_arbiter.sv
  - bus_decoder.sv
  - sys_ctrl_regs.sv
  - wb_ram.sv
  - sseg_display.sv
  - soc_bus_top.sv
  - target: simulation
    files:
      - soc_bus_tb.sv
